//--- sim/fifo_stim.txt
# op and fields: T name, W word ack, R byte, B word ack byte, U byte, I cycles,
# M count base, P count base (word k = base + k * 01010101), C wr_cnt rd_cnt wr_space rd_space
# F bits msb first: full empty wr_ready afull aempty pfull pempty valid overflow underflow
T reset
F 0110101000
C 0 0 16 64
T order
W 11223344 1
W 55667788 1
R 11
R 22
W 99aabbcc 1
R 33
R 44
B deadbeef 1 55
B dfafbff0 1 66
R 77
T counts
I 1
C 4 13 12 51
F 0010000100
T drain
R 88
R 99
R aa
I 1
F 0010001100
R bb
R cc
P 1 deadbeef
R df
R af
R bf
I 1
F 0010101100
R f0
I 1
F 0110101000
C 0 0 16 64
T underflow
U df
C 0 0 16 64
T full
M 16 10203040
I 1
F 1001010100
C 16 64 0 0
W ffffffff 0
F 1001010110
P 1 10203040
I 1
F 0011010100
C 15 60 1 4
P 15 11213141
I 1
F 0110101000
C 0 0 16 64

//--- verilog.f
hdl/fifo_pkg.sv
hdl/lane_ram.sv
hdl/fifo_pointers.sv
hdl/fwft_prefetch.sv
hdl/lane_select.sv
hdl/fifo_flags.sv
hdl/width_down_fifo.sv
sim/tb_width_down_fifo.sv

//--- Bender.yml
package:
  name: width_down_fifo

sources:
  - hdl/fifo_pkg.sv
  - hdl/lane_ram.sv
  - hdl/fifo_pointers.sv
  - hdl/fwft_prefetch.sv
  - hdl/lane_select.sv
  - hdl/fifo_flags.sv
  - hdl/width_down_fifo.sv
  - target: simulation
    files:
      - sim/tb_width_down_fifo.sv

//--- sim/tb_width_down_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module tb_width_down_fifo
    import fifo_pkg::*;
();

    localparam int max_cmds = 128;
    // step between pattern words of M and P, every lane changes
    localparam logic [31:0] lane_step = 32'h01010101;

    logic                    clock;
    logic                    reset;
    logic                    wr_en;
    logic [wr_width-1:0]     din;
    logic                    rd_en;
    logic                    wr_ready;
    logic [rd_width-1:0]     dout;
    logic                    valid;
    logic                    full;
    logic                    empty;
    logic [wr_addr_bits-1:0] wr_data_count;
    logic [wr_addr_bits-1:0] wr_data_space;
    logic [rd_addr_bits-1:0] rd_data_count;
    logic [rd_addr_bits-1:0] rd_data_space;
    logic                    almost_full;
    logic                    almost_empty;
    logic                    prog_full;
    logic                    prog_empty;
    logic                    overflow;
    logic                    underflow;
    logic                    wr_ack;

    // command table, one entry per stim line
    logic [7:0]   op_mem [max_cmds];
    logic [31:0]  a_mem [max_cmds];
    logic [31:0]  b_mem [max_cmds];
    logic [31:0]  c_mem [max_cmds];
    logic [31:0]  d_mem [max_cmds];
    logic [127:0] name_mem [max_cmds];
    int           n_cmds;
    logic [127:0] test_name;
    int           errors;
    int           checks;
    int           cycles;
    int           cycle_limit;

    width_down_fifo uut (
        .clock         (clock),
        .reset         (reset),
        .wr_en         (wr_en),
        .din           (din),
        .rd_en         (rd_en),
        .wr_ready      (wr_ready),
        .dout          (dout),
        .valid         (valid),
        .full          (full),
        .empty         (empty),
        .wr_data_count (wr_data_count),
        .wr_data_space (wr_data_space),
        .rd_data_count (rd_data_count),
        .rd_data_space (rd_data_space),
        .almost_full   (almost_full),
        .almost_empty  (almost_empty),
        .prog_full     (prog_full),
        .prog_empty    (prog_empty),
        .overflow      (overflow),
        .underflow     (underflow),
        .wr_ack        (wr_ack)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // watchdog, armed once the stim file has been sized
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0s %0s expected %0h actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    // word is taken on the second edge, wr_ack sampled in between
    task automatic write_word(input logic [31:0] word, input logic ack);
        @(posedge clock);
        wr_en <= 1'b1;
        din <= word;
        @(negedge clock);
        check_value("wr_ack", ack, wr_ack);
        @(posedge clock);
        wr_en <= 1'b0;
    endtask

    // wait for valid, check the presented byte, then pop it
    // with_wr adds a write on the same edge as the pop
    task automatic pop_byte(input logic [7:0] expected, input logic with_wr,
                            input logic [31:0] word, input logic ack);
        @(negedge clock);
        while (!valid) begin
            @(negedge clock);
        end
        check_value("dout", expected, dout);
        @(posedge clock);
        rd_en <= 1'b1;
        wr_en <= with_wr;
        din <= word;
        @(negedge clock);
        if (with_wr) begin
            check_value("wr_ack", ack, wr_ack);
        end
        @(posedge clock);
        rd_en <= 1'b0;
        wr_en <= 1'b0;
    endtask

    // msb lane first
    task automatic pop_word(input logic [31:0] word);
        for (int l = lane_num - 1; l >= 0; l--) begin
            pop_byte(word[l*rd_width +: rd_width], 1'b0, '0, 1'b0);
        end
    endtask

    // read with nothing presented, dout must hold
    task automatic request_while_empty(input logic [7:0] expected);
        @(posedge clock);
        rd_en <= 1'b1;
        @(posedge clock);
        rd_en <= 1'b0;
        @(negedge clock);
        check_value("underflow", 1, underflow);
        check_value("dout", expected, dout);
    endtask

    task automatic load_commands();
        int           fd;
        int           r;
        int           cost;
        logic [63:0]  token;
        logic [1023:0] skip_line;
        logic [7:0]   op;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [31:0]  c;
        logic [31:0]  d;
        logic [127:0] name;
        // reset cycles
        cost = 4;
        n_cmds = 0;
        fd = $fopen("sim/fifo_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stim file sim/fifo_stim.txt");
        end else begin
            while (!$feof(fd) && n_cmds < max_cmds) begin
                token = '0;
                name = '0;
                a = '0;
                b = '0;
                c = '0;
                d = '0;
                r = $fscanf(fd, "%s", token);
                op = token[7:0];
                if (r == 1 && op == "#") begin
                    r = $fgets(skip_line, fd);
                end else if (r == 1) begin
                    case (op)
                        "T": r = $fscanf(fd, "%s", name);
                        "W": r = $fscanf(fd, "%h %d", a, b);
                        "B": r = $fscanf(fd, "%h %d %h", a, b, c);
                        "R", "U": r = $fscanf(fd, "%h", a);
                        "I": r = $fscanf(fd, "%d", a);
                        "F": r = $fscanf(fd, "%b", a);
                        "M", "P": r = $fscanf(fd, "%d %h", a, b);
                        "C": r = $fscanf(fd, "%d %d %d %d", a, b, c, d);
                        default: begin
                            errors++;
                            $display("unknown command %0s in the stim file", token);
                        end
                    endcase
                    // rough cycle cost of each command
                    case (op)
                        "W", "R", "B", "U": cost += 3;
                        "M": cost += 2 * a;
                        "P": cost += 12 * a;
                        "I": cost += a;
                        "C", "F": cost += 1;
                        default: ;
                    endcase
                    op_mem[n_cmds] = op;
                    a_mem[n_cmds] = a;
                    b_mem[n_cmds] = b;
                    c_mem[n_cmds] = c;
                    d_mem[n_cmds] = d;
                    name_mem[n_cmds] = name;
                    n_cmds++;
                end
            end
            $fclose(fd);
            cycle_limit = 2 * cost + 100;
        end
    endtask

    task automatic run_command(input int i);
        case (op_mem[i])
            "T": test_name = name_mem[i];
            "W": write_word(a_mem[i], b_mem[i][0]);
            "R": pop_byte(a_mem[i][7:0], 1'b0, '0, 1'b0);
            "B": pop_byte(c_mem[i][7:0], 1'b1, a_mem[i], b_mem[i][0]);
            "U": request_while_empty(a_mem[i][7:0]);
            "I": repeat (a_mem[i]) @(posedge clock);
            "M": begin
                for (int k = 0; k < a_mem[i]; k++) begin
                    write_word(b_mem[i] + k * lane_step, 1'b1);
                end
            end
            "P": begin
                for (int k = 0; k < a_mem[i]; k++) begin
                    pop_word(b_mem[i] + k * lane_step);
                end
            end
            "C": begin
                @(negedge clock);
                check_value("wr_data_count", a_mem[i], wr_data_count);
                check_value("rd_data_count", b_mem[i], rd_data_count);
                check_value("wr_data_space", c_mem[i], wr_data_space);
                check_value("rd_data_space", d_mem[i], rd_data_space);
            end
            "F": begin
                @(negedge clock);
                check_value("flags", a_mem[i], {full, empty, wr_ready, almost_full,
                            almost_empty, prog_full, prog_empty, valid, overflow, underflow});
            end
            default: ;
        endcase
    endtask

    initial begin
        reset = 1'b1;
        wr_en = 1'b0;
        din = '0;
        rd_en = 1'b0;
        test_name = "load";
        errors = 0;
        checks = 0;
        cycles = 0;
        cycle_limit = 0;
        load_commands();
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < n_cmds; i++) begin
            run_command(i);
        end
        @(posedge clock);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/width_down_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module width_down_fifo
    import fifo_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    wr_en,
    input  logic [wr_width-1:0]     din,
    input  logic                    rd_en,
    output logic                    wr_ready,
    output logic [rd_width-1:0]     dout,
    output logic                    valid,
    output logic                    full,
    output logic                    empty,
    output logic [wr_addr_bits-1:0] wr_data_count,
    output logic [wr_addr_bits-1:0] wr_data_space,
    output logic [rd_addr_bits-1:0] rd_data_count,
    output logic [rd_addr_bits-1:0] rd_data_space,
    output logic                    almost_full,
    output logic                    almost_empty,
    output logic                    prog_full,
    output logic                    prog_empty,
    output logic                    overflow,
    output logic                    underflow,
    output logic                    wr_ack
);

    fifo_word_t din_word;
    fifo_word_t ram_word;
    logic [lane_num-1:0][rd_width-1:0] lane_q;
    logic [wr_addr_bits-1:0] wr_ptr;
    logic [rd_addr_bits-1:0] rd_ptr;
    // pointer to the byte after the current one
    logic [rd_addr_bits-1:0] fetch_ptr;
    logic [wr_addr_bits-2:0] ram_rd_addr;
    logic                    lane_wr_en;
    logic                    ram_rd_en;
    logic                    pop;

    assign din_word.flat = din;
    assign ram_word.lanes = lane_q;

    // every lane takes its byte of an accepted word on the same edge
    assign lane_wr_en = wr_en & ~full;

    // fetch address is the word holding the next byte
    // valid low always sits on lane 3, so this is the current word then
    assign fetch_ptr = rd_ptr + 1'b1;
    assign ram_rd_addr = fetch_ptr[rd_addr_bits-2:lane_bits];

    for (genvar i = 0; i < lane_num; i++) begin : g_lane
        lane_ram u_lane_ram (
            .clock   (clock),
            .wr_en   (lane_wr_en),
            .wr_addr (wr_ptr[wr_addr_bits-2:0]),
            .wr_data (din_word.lanes[i]),
            .rd_en   (ram_rd_en),
            .rd_addr (ram_rd_addr),
            .rd_data (lane_q[i])
        );
    end

    fifo_pointers u_pointers (
        .clock         (clock),
        .reset         (reset),
        .wr_en         (wr_en),
        .pop           (pop),
        .wr_ptr        (wr_ptr),
        .rd_ptr        (rd_ptr),
        .full          (full),
        .empty         (empty),
        .wr_data_count (wr_data_count),
        .rd_data_count (rd_data_count)
    );

    fwft_prefetch u_prefetch (
        .clock     (clock),
        .reset     (reset),
        .rd_en     (rd_en),
        .rd_ptr    (rd_ptr),
        .wr_ptr    (wr_ptr),
        .valid     (valid),
        .pop       (pop),
        .ram_rd_en (ram_rd_en)
    );

    lane_select u_lane_select (
        .clock     (clock),
        .reset     (reset),
        .pop       (pop),
        .lane_data (ram_word),
        .dout      (dout)
    );

    fifo_flags u_flags (
        .clock         (clock),
        .reset         (reset),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .full          (full),
        .valid         (valid),
        .wr_data_count (wr_data_count),
        .rd_data_count (rd_data_count),
        .wr_ready      (wr_ready),
        .wr_ack        (wr_ack),
        .wr_data_space (wr_data_space),
        .rd_data_space (rd_data_space),
        .almost_full   (almost_full),
        .almost_empty  (almost_empty),
        .prog_full     (prog_full),
        .prog_empty    (prog_empty),
        .overflow      (overflow),
        .underflow     (underflow)
    );

endmodule

`default_nettype wire

//--- hdl/fifo_flags.sv
`timescale 1ns/100ps
`default_nettype none

module fifo_flags
    import fifo_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    wr_en,
    input  logic                    rd_en,
    input  logic                    full,
    input  logic                    valid,
    input  logic [wr_addr_bits-1:0] wr_data_count,
    input  logic [rd_addr_bits-1:0] rd_data_count,
    output logic                    wr_ready,
    output logic                    wr_ack,
    output logic [wr_addr_bits-1:0] wr_data_space,
    output logic [rd_addr_bits-1:0] rd_data_space,
    output logic                    almost_full,
    output logic                    almost_empty,
    output logic                    prog_full,
    output logic                    prog_empty,
    output logic                    overflow,
    output logic                    underflow
);

    // write handshake
    assign wr_ready = !full;
    assign wr_ack = wr_en && !full;

    // room left on each side
    assign wr_data_space = wr_addr_bits'(wr_depth) - wr_data_count;
    assign rd_data_space = rd_addr_bits'(rd_depth) - rd_data_count;

    // one word short of full
    assign almost_full = (wr_data_count >= wr_addr_bits'(wr_depth - 1));
    // at most one byte left
    assign almost_empty = (rd_data_count <= rd_addr_bits'(1));

    // programmable levels
    assign prog_full = (wr_data_count >= wr_addr_bits'(prog_full_thresh));
    assign prog_empty = (rd_data_count <= rd_addr_bits'(prog_empty_thresh));

    // rejected requests, flagged on the following edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            overflow <= 1'b0;
            underflow <= 1'b0;
        end else begin
            overflow <= wr_en && full;
            // a read with nothing presented
            underflow <= rd_en && !valid;
        end
    end

endmodule

`default_nettype wire

//--- hdl/lane_select.sv
`timescale 1ns/100ps
`default_nettype none

module lane_select
    import fifo_pkg::*;
(
    input  logic                clock,
    input  logic                reset,
    input  logic                pop,
    input  fifo_word_t          lane_data,
    output logic [rd_width-1:0] dout
);

    // one hot, bit i picks lane i
    logic [lane_num-1:0] sel;

    // start on the msb lane, step down one lane per pop, then wrap
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            sel <= {1'b1, {(lane_num-1){1'b0}}};
        end else if (pop) begin
            sel <= {sel[0], sel[lane_num-1:1]};
        end
    end

    // byte mux from the lane ram outputs
    always_comb begin
        dout = '0;
        for (int i = 0; i < lane_num; i++) begin
            if (sel[i]) begin
                dout = lane_data.lanes[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/fwft_prefetch.sv
`timescale 1ns/100ps
`default_nettype none

module fwft_prefetch
    import fifo_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    rd_en,
    input  logic [rd_addr_bits-1:0] rd_ptr,
    input  logic [wr_addr_bits-1:0] wr_ptr,
    output logic                    valid,
    output logic                    pop,
    output logic                    ram_rd_en
);

    // write pointer as seen by the read side, one cycle late
    logic [wr_addr_bits-1:0] wr_seen;
    logic [wr_addr_bits-1:0] rd_word;
    logic                    last_lane;
    logic                    word_here;
    logic                    word_next;
    logic                    last_pop;

    assign rd_word = rd_ptr[rd_addr_bits-1:lane_bits];
    // lane 0 is the last byte of a word
    assign last_lane = &rd_ptr[lane_bits-1:0];

    // the word under the read pointer is stored
    assign word_here = (wr_seen != rd_word);
    // the word after it is stored too
    assign word_next = (wr_seen != rd_word + 1'b1);

    assign pop = rd_en & valid;
    assign last_pop = pop & last_lane;

    // fetch when idle with data waiting, or when the last byte leaves
    // and another word can follow without a gap
    assign ram_rd_en = (!valid && word_here) || (last_pop && word_next);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_seen <= '0;
        end else begin
            wr_seen <= wr_ptr;
        end
    end

    // valid marks a fetched word on the ram output
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (ram_rd_en) begin
            valid <= 1'b1;
        end else if (last_pop) begin
            // word used up and nothing behind it
            valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fifo_pointers.sv
`timescale 1ns/100ps
`default_nettype none

module fifo_pointers
    import fifo_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    wr_en,
    input  logic                    pop,
    output logic [wr_addr_bits-1:0] wr_ptr,
    output logic [rd_addr_bits-1:0] rd_ptr,
    output logic                    full,
    output logic                    empty,
    output logic [wr_addr_bits-1:0] wr_data_count,
    output logic [rd_addr_bits-1:0] rd_data_count
);

    // word the read side is working on, with its wrap bit
    logic [wr_addr_bits-1:0] rd_word;

    assign rd_word = rd_ptr[rd_addr_bits-1:lane_bits];

    // same slot, opposite wrap bit
    assign full = (wr_ptr[wr_addr_bits-1] != rd_word[wr_addr_bits-1]) &&
                  (wr_ptr[wr_addr_bits-2:0] == rd_word[wr_addr_bits-2:0]);

    // a word is only released after its last byte, so equal words mean no bytes
    assign empty = (wr_ptr == rd_word);

    // word write pointer, moves on an accepted write
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr_en && !full) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // byte read pointer, moves on every pop
    // low bits step through the lanes msb first
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // counts lag the pointers by one cycle
    // a word being presented still counts until its last byte is popped
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_data_count <= '0;
            rd_data_count <= '0;
        end else begin
            wr_data_count <= wr_ptr - rd_word;
            // bytes written minus bytes popped
            rd_data_count <= {wr_ptr, {lane_bits{1'b0}}} - rd_ptr;
        end
    end

endmodule

`default_nettype wire

//--- hdl/lane_ram.sv
`timescale 1ns/100ps
`default_nettype none

module lane_ram
    import fifo_pkg::*;
(
    input  logic                    clock,
    input  logic                    wr_en,
    input  logic [wr_addr_bits-2:0] wr_addr,
    input  logic [rd_width-1:0]     wr_data,
    input  logic                    rd_en,
    input  logic [wr_addr_bits-2:0] rd_addr,
    output logic [rd_width-1:0]     rd_data
);

    // one byte per word slot
    logic [rd_width-1:0] mem [wr_depth];

    // write port, all lanes share the address and strobe
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read port
    // without the strobe the last fetched byte stays on rd_data
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

    // word width on the write side, byte width on the read side
    localparam int wr_width = 32;
    localparam int rd_width = 8;

    // one lane ram per byte of the word
    localparam int lane_num = wr_width / rd_width;
    // bits of the read pointer that select the byte within a word
    localparam int lane_bits = $clog2(lane_num);

    // depth in words, and the same storage counted in bytes
    localparam int wr_depth = 16;
    localparam int rd_depth = lane_num * wr_depth;

    // pointers carry one wrap bit above the address
    localparam int wr_addr_bits = $clog2(wr_depth) + 1;
    localparam int rd_addr_bits = $clog2(rd_depth) + 1;

    // prog_full compares words, prog_empty compares bytes
    localparam int prog_full_thresh = 12;
    localparam int prog_empty_thresh = 10;

    // a stored word, seen whole or as byte lanes
    // lane 3 holds the most significant byte and is read first
    typedef union packed {
        logic [wr_width-1:0] flat;
        logic [lane_num-1:0][rd_width-1:0] lanes;
    } fifo_word_t;

endpackage

`default_nettype wire
